//--- all.f
source/idiv_cfg_pkg.sv
source/idiv_ctrl_pkg.sv
source/idiv_lane_if.sv
source/idiv_controller.sv
source/idiv_iterative.sv
source/idiv_dispatch.sv
source/idiv_collect.sv
source/idiv_array_top.sv
testbench/tb_idiv_array.sv

//--- testbench/idiv_input.txt
// columns: op (0 unsigned, 1 signed), dividend, divisor, quotient, remainder
// all values in hex, one request per line, issued top to bottom
0 00000064 00000007 0000000E 00000002
0 FFFFFFFF 00000010 0FFFFFFF 0000000F
0 00000005 00000009 00000000 00000005
0 80000000 00000003 2AAAAAAA 00000002
0 12345678 00001000 00012345 00000678
0 FFFFFFFF FFFFFFFF 00000001 00000000
0 FFFFFFFE FFFFFFFF 00000000 FFFFFFFE
0 00000000 00000005 00000000 00000000
0 DEADBEEF 00000001 DEADBEEF 00000000
0 0000FFFF 00000100 000000FF 000000FF
1 00000064 00000007 0000000E 00000002
1 FFFFFF9C 00000007 FFFFFFF2 FFFFFFFE
1 00000064 FFFFFFF9 FFFFFFF2 00000002
1 FFFFFF9C FFFFFFF9 0000000E FFFFFFFE
1 00000007 FFFFFF9C 00000000 00000007
1 FFFFFFF9 00000064 00000000 FFFFFFF9
1 80000000 FFFFFFFF 80000000 00000000
1 80000000 00000002 C0000000 00000000
1 7FFFFFFF FFFFFFFF 80000001 00000000
1 FFFFFFFF 00000002 00000000 FFFFFFFF
1 80000000 7FFFFFFF FFFFFFFF FFFFFFFF
0 12345678 00000000 FFFFFFFF 12345678
1 12345678 00000000 FFFFFFFF 12345678
1 FFFFFF9C 00000000 FFFFFFFF FFFFFF9C
0 00000000 00000000 FFFFFFFF 00000000
1 80000000 00000000 FFFFFFFF 80000000

//--- testbench/tb_idiv_array.sv
// testbench for the multi-lane divide unit
// file-driven requests, random back-pressure, in-order result checks
`timescale 1ns/1ps

module tb_idiv_array;

  localparam int width_c     = idiv_cfg_pkg::width_c;
  localparam int lanes_c     = idiv_cfg_pkg::lanes_c;
  localparam int num_vec_c   = 26;
  localparam int stall_len_c = 2 * (width_c + 8);
  localparam int timeout_c   = num_vec_c * (width_c + 8 + lanes_c) * 4;

  logic                    clk_i = 1'b0;
  logic                    rst_n_i;
  logic                    v_i;
  logic                    ready_and_o;
  logic [width_c-1:0]      dividend_i;
  logic [width_c-1:0]      divisor_i;
  idiv_ctrl_pkg::idiv_op_e op_i;
  logic                    v_o;
  logic [width_c-1:0]      quotient_o;
  logic [width_c-1:0]      remainder_o;
  logic                    yumi_i;

  // each vector is five words of op, dividend, divisor, quotient and remainder
  logic [width_c-1:0] vec_mem [num_vec_c*5];
  logic [width_c-1:0] exp_quot_q [$];
  logic [width_c-1:0] exp_rem_q [$];

  logic [31:0] rnd_r;
  int          sent;
  int          checked;
  int          outstanding;
  int          stall_cnt;
  int          cycle_cnt = 0;
  bit          stall_done;
  bit          took;

  idiv_array_top UUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .v_i         (v_i),
    .ready_and_o (ready_and_o),
    .dividend_i  (dividend_i),
    .divisor_i   (divisor_i),
    .op_i        (op_i),
    .v_o         (v_o),
    .quotient_o  (quotient_o),
    .remainder_o (remainder_o),
    .yumi_i      (yumi_i)
  );

  always #2 clk_i = ~clk_i;

  // ------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_quotient(input logic [width_c-1:0] exp_v, input logic [width_c-1:0] got_v);
    if (got_v !== exp_v)
      report_failure($sformatf("Fail at %0t ns: quotient_o expected %h got %h",
                               $time, exp_v, got_v));
  endtask

  task automatic check_remainder(input logic [width_c-1:0] exp_v,
                                 input logic [width_c-1:0] got_v);
    if (got_v !== exp_v)
      report_failure($sformatf("Fail at %0t ns: remainder_o expected %h got %h",
                               $time, exp_v, got_v));
  endtask

  task automatic check_flag(input logic exp_v, input logic got_v, input string name);
    if (got_v !== exp_v)
      report_failure($sformatf("Fail at %0t ns: %s expected %b got %b",
                               $time, name, exp_v, got_v));
  endtask

  // ------------------------------------------------------------------
  // watchdog
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_c)
      report_failure("timeout: results stopped arriving before all vectors were checked");
  end

  // ------------------------------------------------------------------
  // drive stimulus and sample outputs at each rising edge
  initial begin
    rst_n_i    = 1'b0;
    v_i        = 1'b0;
    dividend_i = '0;
    divisor_i  = '0;
    op_i       = idiv_ctrl_pkg::IDIV_OP_DIVU;
    yumi_i     = 1'b0;
    rnd_r      = 32'd42;
    sent       = 0;
    checked    = 0;
    stall_cnt  = 0;
    stall_done = 1'b0;
    $readmemh("testbench/idiv_input.txt", vec_mem);

    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_flag(1'b1, ready_and_o, "ready_and_o");
    check_flag(1'b0, v_o, "v_o");

    while (checked < num_vec_c) begin
      @(posedge clk_i);
      rnd_r = lcg_next(rnd_r);
      took  = 1'b0;

      // the issue lane is busy only when every lane holds a request
      outstanding = sent - checked;
      check_flag(logic'(outstanding < lanes_c), ready_and_o, "ready_and_o");

      // a held result must still be on the port while yumi is high
      if (yumi_i)
        check_flag(1'b1, v_o, "v_o");

      if (v_i && ready_and_o) begin
        exp_quot_q.push_back(vec_mem[sent*5+3]);
        exp_rem_q.push_back(vec_mem[sent*5+4]);
        sent++;
      end

      if (v_o && yumi_i) begin
        if (exp_quot_q.size() == 0) begin
          report_failure("a result arrived with no request pending");
        end else begin
          check_quotient(exp_quot_q.pop_front(), quotient_o);
          check_remainder(exp_rem_q.pop_front(), remainder_o);
          checked++;
          took = 1'b1;
        end
      end

      // a stalled request stays on the port until accepted
      if (!(v_i && !ready_and_o)) begin
        if (sent < num_vec_c && (sent < 2 * lanes_c || rnd_r[21:20] != 2'b00)) begin
          v_i        <= 1'b1;
          op_i       <= idiv_ctrl_pkg::idiv_op_e'(vec_mem[sent*5][0]);
          dividend_i <= vec_mem[sent*5+1];
          divisor_i  <= vec_mem[sent*5+2];
        end else begin
          v_i <= 1'b0;
        end
      end

      // long yumi stall when the lanes first fill and again now and then
      if (!stall_done && sent == lanes_c) begin
        stall_cnt  = stall_len_c;
        stall_done = 1'b1;
      end else if (stall_cnt == 0 && rnd_r[30:25] == 6'd0) begin
        stall_cnt = stall_len_c;
      end
      if (stall_cnt != 0)
        stall_cnt--;

      // yumi only while a held result is still on the port
      if (stall_cnt == 0 && v_o && !took && rnd_r[17:16] != 2'b00)
        yumi_i <= 1'b1;
      else
        yumi_i <= 1'b0;
    end

    v_i    <= 1'b0;
    yumi_i <= 1'b0;

    // no extra result may show up once every vector is drained
    repeat (width_c + 8) begin
      @(posedge clk_i);
      check_flag(1'b0, v_o, "v_o");
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- source/idiv_array_top.sv
// multi-lane iterative divide unit
// dispatcher, lane array and in-order collector
`timescale 1ns/1ps

module idiv_array_top #(
  parameter int width_p = idiv_cfg_pkg::width_c,
  parameter int lanes_p = idiv_cfg_pkg::lanes_c
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  input  logic                    v_i,
  output logic                    ready_and_o,
  input  logic [width_p-1:0]      dividend_i,
  input  logic [width_p-1:0]      divisor_i,
  input  idiv_ctrl_pkg::idiv_op_e op_i,

  output logic                    v_o,
  output logic [width_p-1:0]      quotient_o,
  output logic [width_p-1:0]      remainder_o,
  input  logic                    yumi_i
);

  idiv_lane_if #(.width_p(width_p)) lane_if [lanes_p] ();

  idiv_dispatch #(
    .width_p (width_p),
    .lanes_p (lanes_p)
  ) u_dispatch (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .v_i         (v_i),
    .dividend_i  (dividend_i),
    .divisor_i   (divisor_i),
    .op_i        (op_i),
    .ready_and_o (ready_and_o),
    .lanes_io    (lane_if)
  );

  for (genvar g = 0; g < lanes_p; g++) begin : g_lane
    idiv_iterative #(
      .width_p (width_p)
    ) u_lane (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .lane_io (lane_if[g])
    );
  end

  idiv_collect #(
    .width_p (width_p),
    .lanes_p (lanes_p)
  ) u_collect (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .lanes_io    (lane_if),
    .v_o         (v_o),
    .quotient_o  (quotient_o),
    .remainder_o (remainder_o),
    .yumi_i      (yumi_i)
  );

endmodule

//--- source/idiv_collect.sv
// in-order result drain from the divider lanes
`timescale 1ns/1ps

module idiv_collect #(
  parameter int width_p = 32,
  parameter int lanes_p = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  idiv_lane_if.collect       lanes_io [lanes_p],
  output logic               v_o,
  output logic [width_p-1:0] quotient_o,
  output logic [width_p-1:0] remainder_o,
  input  logic               yumi_i
);

  localparam int ptr_w_lp = $clog2(lanes_p);

  logic [ptr_w_lp-1:0] drain_ptr_r;
  logic [lanes_p-1:0]  lane_v;
  logic [width_p-1:0]  lane_quot [lanes_p];
  logic [width_p-1:0]  lane_rem  [lanes_p];

  // results leave in the same lane order as issue
  for (genvar g = 0; g < lanes_p; g++) begin : g_lane
    assign lane_v[g]        = lanes_io[g].v_res;
    assign lane_quot[g]     = lanes_io[g].quotient;
    assign lane_rem[g]      = lanes_io[g].remainder;
    assign lanes_io[g].yumi = yumi_i & (drain_ptr_r == ptr_w_lp'(g));
  end

  assign v_o         = lane_v[drain_ptr_r];
  assign quotient_o  = lane_quot[drain_ptr_r];
  assign remainder_o = lane_rem[drain_ptr_r];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      drain_ptr_r <= '0;
    end else if (yumi_i) begin
      drain_ptr_r <= (drain_ptr_r == ptr_w_lp'(lanes_p - 1)) ? '0 : drain_ptr_r + 1'b1;
    end
  end

endmodule

//--- source/idiv_dispatch.sv
// round-robin request issue to the divider lanes
`timescale 1ns/1ps

module idiv_dispatch #(
  parameter int width_p = 32,
  parameter int lanes_p = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    v_i,
  input  logic [width_p-1:0]      dividend_i,
  input  logic [width_p-1:0]      divisor_i,
  input  idiv_ctrl_pkg::idiv_op_e op_i,
  output logic                    ready_and_o,
  idiv_lane_if.dispatch           lanes_io [lanes_p]
);

  localparam int ptr_w_lp = $clog2(lanes_p);

  logic [ptr_w_lp-1:0] issue_ptr_r;
  logic [lanes_p-1:0]  lane_ready;

  // valid goes only to the lane under the issue pointer
  for (genvar g = 0; g < lanes_p; g++) begin : g_lane
    assign lanes_io[g].v        = v_i & (issue_ptr_r == ptr_w_lp'(g));
    assign lanes_io[g].dividend = dividend_i;
    assign lanes_io[g].divisor  = divisor_i;
    assign lanes_io[g].op       = op_i;
    assign lane_ready[g]        = lanes_io[g].ready_and;
  end

  assign ready_and_o = lane_ready[issue_ptr_r];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      issue_ptr_r <= '0;
    end else if (v_i && ready_and_o) begin
      issue_ptr_r <= (issue_ptr_r == ptr_w_lp'(lanes_p - 1)) ? '0 : issue_ptr_r + 1'b1;
    end
  end

endmodule

//--- source/idiv_iterative.sv
// one iterative divider lane
// operand registers A, B, C, one-hot muxes, shared adder and its FSM
`timescale 1ns/1ps

module idiv_iterative #(
  parameter int width_p = 32
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  idiv_lane_if.lane       lane_io
);

  // A holds the divisor, later the remainder
  // B holds the partial remainder, C the dividend, later the quotient
  logic [width_p:0] opa_r;
  logic [width_p:0] opb_r;
  logic [width_p:0] opc_r;
  logic             signed_div_r;

  logic [width_p:0] opa_mux;
  logic [width_p:0] opb_mux;
  logic [width_p:0] opc_mux;
  logic [width_p:0] add_in_a;
  logic [width_p:0] add_in_b;
  logic [width_p:0] add_out;
  logic [width_p:0] divisor_ext;
  logic [width_p:0] dividend_ext;

  logic [1:0] opa_sel;
  logic [2:0] opb_sel;
  logic [2:0] opc_sel;
  logic       opa_ld;
  logic       opb_ld;
  logic       opc_ld;
  logic       opa_inv;
  logic       opb_inv;
  logic       opa_clr_l;
  logic       opb_clr_l;
  logic       adder_cin;
  logic       latch_signed;
  logic       signed_req;
  logic       zero_divisor;
  logic       q_bit;

  idiv_ctrl_pkg::idiv_state_e state;

  // sign extension only for signed requests
  assign signed_req   = (lane_io.op == idiv_ctrl_pkg::IDIV_OP_DIV);
  assign divisor_ext  = {signed_req & lane_io.divisor[width_p-1], lane_io.divisor};
  assign dividend_ext = {signed_req & lane_io.dividend[width_p-1], lane_io.dividend};

  assign zero_divisor = ~(|opa_r);

  // quotient bit is the inverted adder sign, only while iterating
  assign q_bit = (state == idiv_ctrl_pkg::ITERATE) & ~add_out[width_p];

  // ------------------------------------------------------------------
  // one-hot operand muxes
  assign opa_mux = ({(width_p+1){opa_sel[1]}} & divisor_ext)
                 | ({(width_p+1){opa_sel[0]}} & add_out);

  assign opb_mux = ({(width_p+1){opb_sel[2]}} & opc_r)
                 | ({(width_p+1){opb_sel[1]}} & add_out)
                 | ({(width_p+1){opb_sel[0]}} & {add_out[width_p-1:0], opc_r[width_p-1]});

  assign opc_mux = ({(width_p+1){opc_sel[2]}} & dividend_ext)
                 | ({(width_p+1){opc_sel[1]}} & add_out)
                 | ({(width_p+1){opc_sel[0]}} & {opc_r[width_p-1:0], q_bit});

  // ------------------------------------------------------------------
  // adder with operand inversion and clear
  assign add_in_a = (opa_r ^ {(width_p+1){opa_inv}}) & {(width_p+1){opa_clr_l}};
  assign add_in_b = (opb_r ^ {(width_p+1){opb_inv}}) & {(width_p+1){opb_clr_l}};
  assign add_out  = add_in_a + add_in_b + {{width_p{1'b0}}, adder_cin};

  always_ff @(posedge clk_i) begin
    if (opa_ld) opa_r <= opa_mux;
    if (opb_ld) opb_r <= opb_mux;
    if (opc_ld) opc_r <= opc_mux;
    if (latch_signed) signed_div_r <= signed_req;
  end

  assign lane_io.quotient  = opc_r[width_p-1:0];
  assign lane_io.remainder = opa_r[width_p-1:0];

  idiv_controller #(
    .width_p (width_p)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .v_i            (lane_io.v),
    .ready_and_o    (lane_io.ready_and),
    .zero_divisor_i (zero_divisor),
    .signed_div_r_i (signed_div_r),
    .adder_neg_i    (add_out[width_p]),
    .opa_neg_i      (opa_r[width_p]),
    .opc_neg_i      (opc_r[width_p]),
    .opa_sel_o      (opa_sel),
    .opb_sel_o      (opb_sel),
    .opc_sel_o      (opc_sel),
    .opa_ld_o       (opa_ld),
    .opb_ld_o       (opb_ld),
    .opc_ld_o       (opc_ld),
    .opa_inv_o      (opa_inv),
    .opb_inv_o      (opb_inv),
    .opa_clr_l_o    (opa_clr_l),
    .opb_clr_l_o    (opb_clr_l),
    .adder_cin_o    (adder_cin),
    .latch_signed_o (latch_signed),
    .state_o        (state),
    .v_o            (lane_io.v_res),
    .yumi_i         (lane_io.yumi)
  );

endmodule

//--- source/idiv_controller.sv
// sequencing FSM for one iterative divider lane
// drives register selects, loads and adder controls of the datapath
`timescale 1ns/1ps

module idiv_controller #(
  parameter int width_p = 32
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  logic                       v_i,
  output logic                       ready_and_o,

  input  logic                       zero_divisor_i,
  input  logic                       signed_div_r_i,
  input  logic                       adder_neg_i,
  input  logic                       opa_neg_i,
  input  logic                       opc_neg_i,

  output logic [1:0]                 opa_sel_o,
  output logic [2:0]                 opb_sel_o,
  output logic [2:0]                 opc_sel_o,
  output logic                       opa_ld_o,
  output logic                       opb_ld_o,
  output logic                       opc_ld_o,
  output logic                       opa_inv_o,
  output logic                       opb_inv_o,
  output logic                       opa_clr_l_o,
  output logic                       opb_clr_l_o,
  output logic                       adder_cin_o,
  output logic                       latch_signed_o,

  output idiv_ctrl_pkg::idiv_state_e state_o,
  output logic                       v_o,
  input  logic                       yumi_i
);

  localparam int cnt_w_lp = $clog2(width_p);

  idiv_ctrl_pkg::idiv_state_e state_r, state_n;
  logic [cnt_w_lp-1:0]        cnt_r;
  logic                       neg_last_r;
  logic                       divisor_neg_r;
  logic                       dividend_neg_r;
  logic                       zero_div_r;
  logic                       last_iter;

  assign last_iter   = (cnt_r == '0);
  assign ready_and_o = (state_r == idiv_ctrl_pkg::IDLE);
  assign v_o         = (state_r == idiv_ctrl_pkg::DONE);
  assign state_o     = state_r;

  // ------------------------------------------------------------------
  // next state
  always_comb begin
    state_n = state_r;
    case (state_r)
      idiv_ctrl_pkg::IDLE:         if (v_i) state_n = idiv_ctrl_pkg::LATCH;
      idiv_ctrl_pkg::LATCH:        state_n = idiv_ctrl_pkg::NEG_DIVISOR;
      idiv_ctrl_pkg::NEG_DIVISOR:  state_n = idiv_ctrl_pkg::NEG_DIVIDEND;
      idiv_ctrl_pkg::NEG_DIVIDEND: state_n = idiv_ctrl_pkg::SHIFT;
      idiv_ctrl_pkg::SHIFT:        state_n = idiv_ctrl_pkg::ITERATE;
      idiv_ctrl_pkg::ITERATE:      if (last_iter) state_n = idiv_ctrl_pkg::REPAIR;
      idiv_ctrl_pkg::REPAIR:       state_n = idiv_ctrl_pkg::NEG_REM;
      idiv_ctrl_pkg::NEG_REM:      state_n = idiv_ctrl_pkg::NEG_QUOT;
      idiv_ctrl_pkg::NEG_QUOT:     state_n = idiv_ctrl_pkg::DONE;
      idiv_ctrl_pkg::DONE:         if (yumi_i) state_n = idiv_ctrl_pkg::IDLE;
      default:                     state_n = idiv_ctrl_pkg::IDLE;
    endcase
  end

  // ------------------------------------------------------------------
  // datapath controls, the adder computes (A op) + (B op) + cin
  always_comb begin
    opa_sel_o      = '0;
    opb_sel_o      = '0;
    opc_sel_o      = '0;
    opa_ld_o       = 1'b0;
    opb_ld_o       = 1'b0;
    opc_ld_o       = 1'b0;
    opa_inv_o      = 1'b0;
    opb_inv_o      = 1'b0;
    opa_clr_l_o    = 1'b1;
    opb_clr_l_o    = 1'b1;
    adder_cin_o    = 1'b0;
    latch_signed_o = 1'b0;
    case (state_r)
      idiv_ctrl_pkg::IDLE: begin
        // capture divisor into A and dividend into C on acceptance
        opa_sel_o      = 2'b10;
        opc_sel_o      = 3'b100;
        opa_ld_o       = v_i;
        opc_ld_o       = v_i;
        latch_signed_o = v_i;
      end
      idiv_ctrl_pkg::LATCH: begin
        // copy dividend into B so it can reach the adder
        opb_sel_o = 3'b100;
        opb_ld_o  = 1'b1;
      end
      idiv_ctrl_pkg::NEG_DIVISOR: begin
        opa_inv_o   = 1'b1;
        opb_clr_l_o = 1'b0;
        adder_cin_o = 1'b1;
        opa_sel_o   = 2'b01;
        opa_ld_o    = signed_div_r_i & opa_neg_i;
      end
      idiv_ctrl_pkg::NEG_DIVIDEND: begin
        opa_clr_l_o = 1'b0;
        opb_inv_o   = 1'b1;
        adder_cin_o = 1'b1;
        opc_sel_o   = 3'b010;
        opc_ld_o    = signed_div_r_i & opc_neg_i;
      end
      idiv_ctrl_pkg::SHIFT: begin
        // zero partial remainder, pull in the dividend msb
        opa_clr_l_o = 1'b0;
        opb_clr_l_o = 1'b0;
        opb_sel_o   = 3'b001;
        opc_sel_o   = 3'b001;
        opb_ld_o    = 1'b1;
        opc_ld_o    = 1'b1;
      end
      idiv_ctrl_pkg::ITERATE: begin
        // subtract after a positive result, add after a negative one
        opa_inv_o   = ~neg_last_r;
        adder_cin_o = ~neg_last_r;
        opb_sel_o   = last_iter ? 3'b010 : 3'b001;
        opc_sel_o   = 3'b001;
        opb_ld_o    = 1'b1;
        opc_ld_o    = 1'b1;
      end
      idiv_ctrl_pkg::REPAIR: begin
        // divisor is added back only for a negative remainder
        opa_clr_l_o = neg_last_r;
        opa_sel_o   = 2'b01;
        opa_ld_o    = 1'b1;
      end
      idiv_ctrl_pkg::NEG_REM: begin
        opa_inv_o   = 1'b1;
        opb_clr_l_o = 1'b0;
        adder_cin_o = 1'b1;
        opa_sel_o   = 2'b01;
        opa_ld_o    = dividend_neg_r;
        opb_sel_o   = 3'b100;
        opb_ld_o    = 1'b1;
      end
      idiv_ctrl_pkg::NEG_QUOT: begin
        // a zero divisor keeps the all-ones quotient
        opa_clr_l_o = 1'b0;
        opb_inv_o   = 1'b1;
        adder_cin_o = 1'b1;
        opc_sel_o   = 3'b010;
        opc_ld_o    = (divisor_neg_r ^ dividend_neg_r) & ~zero_div_r;
      end
      default: begin
      end
    endcase
  end

  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r        <= idiv_ctrl_pkg::IDLE;
      cnt_r          <= '0;
      neg_last_r     <= 1'b0;
      divisor_neg_r  <= 1'b0;
      dividend_neg_r <= 1'b0;
      zero_div_r     <= 1'b0;
    end else begin
      state_r <= state_n;
      case (state_r)
        idiv_ctrl_pkg::NEG_DIVISOR: begin
          divisor_neg_r <= signed_div_r_i & opa_neg_i;
          zero_div_r    <= zero_divisor_i;
        end
        idiv_ctrl_pkg::NEG_DIVIDEND: dividend_neg_r <= signed_div_r_i & opc_neg_i;
        idiv_ctrl_pkg::SHIFT: begin
          neg_last_r <= 1'b0;
          cnt_r      <= cnt_w_lp'(width_p - 1);
        end
        idiv_ctrl_pkg::ITERATE: begin
          neg_last_r <= adder_neg_i;
          cnt_r      <= cnt_r - 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

//--- source/idiv_lane_if.sv
// request and result bundle between the array and one divider lane
`timescale 1ns/1ps

interface idiv_lane_if #(
  parameter int width_p = 32
);

  // request side, v/ready_and
  logic                     v;
  logic                     ready_and;
  logic [width_p-1:0]       dividend;
  logic [width_p-1:0]       divisor;
  idiv_ctrl_pkg::idiv_op_e  op;

  // result side, held until yumi
  logic                     v_res;
  logic [width_p-1:0]       quotient;
  logic [width_p-1:0]       remainder;
  logic                     yumi;

  modport dispatch (output v, dividend, divisor, op, input ready_and);

  modport lane (
    input  v, dividend, divisor, op, yumi,
    output ready_and, v_res, quotient, remainder
  );

  modport collect (input v_res, quotient, remainder, output yumi);

endinterface

//--- source/idiv_ctrl_pkg.sv
// control encodings for the divide unit
// request opcode and lane FSM states

package idiv_ctrl_pkg;

  // request opcode, unsigned or signed division
  typedef enum logic {
    IDIV_OP_DIVU = 1'b0,
    IDIV_OP_DIV  = 1'b1
  } idiv_op_e;

  // lane sequencing states, in execution order
  typedef enum logic [3:0] {
    IDLE         = 4'd0,
    LATCH        = 4'd1,
    NEG_DIVISOR  = 4'd2,
    NEG_DIVIDEND = 4'd3,
    SHIFT        = 4'd4,
    ITERATE      = 4'd5,
    REPAIR       = 4'd6,
    NEG_REM      = 4'd7,
    NEG_QUOT     = 4'd8,
    DONE         = 4'd9
  } idiv_state_e;

endpackage

//--- source/idiv_cfg_pkg.sv
// size defaults for the divide array
// operand width and number of divider lanes

package idiv_cfg_pkg;

  // ------------------------------------------------------------------
  // operand width in bits, even and at least 8
  localparam int width_c = 32;

  // number of iterative divider lanes, at least 2
  localparam int lanes_c = 4;
  // ------------------------------------------------------------------

endpackage
